// File: Makefile
.PHONY: build run clean

build:
	verilator --binary --timing --assert -f verilog.f --top-module tb_keypad -o Vtb_keypad

run: build
	./obj_dir/Vtb_keypad

clean:
	rm -rf obj_dir

// File: ascii_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_settings.svh"

module ascii_encoder
  import keypad_pkg::*;
(
  input  logic [3:0] row,
  input  logic [3:0] col,
  input  tap_state_e tap,
  output logic [7:0] ascii_character // Zero when nothing valid
);
  logic [7:0] base;      // First letter of the set
  logic [2:0] n_letters; // Set size, zero for non-letter keys
  logic [1:0] idx;
  logic       tap_ok;

  // Phone layout
  always_comb begin
    case ({row, col})
      `KEY_2:  {base, n_letters} = {"A", 3'd3};
      `KEY_3:  {base, n_letters} = {"D", 3'd3};
      `KEY_4:  {base, n_letters} = {"G", 3'd3};
      `KEY_5:  {base, n_letters} = {"J", 3'd3};
      `KEY_6:  {base, n_letters} = {"M", 3'd3};
      `KEY_7:  {base, n_letters} = {"P", 3'd4}; // PQRS
      `KEY_8:  {base, n_letters} = {"T", 3'd3};
      `KEY_9:  {base, n_letters} = {"W", 3'd4}; // WXYZ
      default: {base, n_letters} = {8'h00, 3'd0};
    endcase
  end

  always_comb begin
    case (tap)
      TAP0:    {tap_ok, idx} = {1'b1, 2'd0};
      TAP1:    {tap_ok, idx} = {1'b1, 2'd1};
      TAP2:    {tap_ok, idx} = {1'b1, 2'd2};
      TAP3:    {tap_ok, idx} = {1'b1, 2'd3};
      default: {tap_ok, idx} = {1'b0, 2'd0}; // IDLE selects nothing
    endcase
  end

  // TAP3 on a three-letter key falls outside the set
  assign ascii_character = (tap_ok && ({1'b0, idx} < n_letters)) ?
                           base + {6'b0, idx} : 8'h00;

endmodule

`default_nettype wire

// File: key_scanner.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_settings.svh"

module key_scanner (
  input  logic       clk,
  input  logic       nRst,
  input  logic [3:0] rows,      // Bit 3 is row 0
  output logic [3:0] col_drive, // One-hot, bit 3 is column 0
  output logic       strobe,    // One pulse per press
  output logic [7:0] cur_key    // Valid with strobe
);
  localparam int DIV_W = $clog2(`SCAN_DIV) + 1;
  localparam int CNT_W = $clog2(`DEBOUNCE_SCANS) + 1;

  logic [DIV_W-1:0] div_cnt;     // Position inside a column slot
  logic [7:0]       scan_key;    // First key seen in the scan so far
  logic [7:0]       last_key;    // Result of the previous scan
  logic [CNT_W-1:0] same_cnt;    // Identical scans in a row
  logic             armed;       // Cleared after a strobe until an empty scan
  logic [3:0]       first_row;
  logic [7:0]       sample_key;
  logic [7:0]       scan_result;
  logic [CNT_W-1:0] cnt_next;
  logic             slot_end;
  logic             scan_end;
  logic             fire;

  always_comb begin
    casez (rows) // Lowest row index wins within a column
      4'b1???: first_row = 4'b1000;
      4'b01??: first_row = 4'b0100;
      4'b001?: first_row = 4'b0010;
      4'b0001: first_row = 4'b0001;
      default: first_row = 4'b0000;
    endcase
  end

  assign sample_key  = (rows != 4'b0000) ? {first_row, col_drive} : 8'h00;
  assign scan_result = (scan_key != 8'h00) ? scan_key : sample_key; // Earlier column wins
  assign slot_end    = (div_cnt == DIV_W'(`SCAN_DIV - 1));
  assign scan_end    = slot_end && col_drive[0]; // Last column sampled

  always_comb begin
    if (scan_result != last_key)
      cnt_next = CNT_W'(1);
    else if (same_cnt < CNT_W'(`DEBOUNCE_SCANS))
      cnt_next = same_cnt + 1'b1;
    else
      cnt_next = same_cnt; // Saturate while held
  end

  assign fire = scan_end && armed && (scan_result != 8'h00) &&
                (cnt_next == CNT_W'(`DEBOUNCE_SCANS));

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      div_cnt   <= '0;
      col_drive <= 4'b1000; // Column 0 first
      scan_key  <= 8'h00;
      last_key  <= 8'h00;
      same_cnt  <= '0;
      armed     <= 1'b1;
      strobe    <= 1'b0;
    end else begin
      strobe  <= fire;
      div_cnt <= slot_end ? '0 : div_cnt + 1'b1;
      if (slot_end) begin
        col_drive <= {col_drive[0], col_drive[3:1]}; // Next column
        scan_key  <= scan_end ? 8'h00 : scan_result;
      end
      if (scan_end) begin
        last_key <= scan_result;
        same_cnt <= cnt_next;
        if (scan_result == 8'h00)
          armed <= 1'b1; // Key released
        else if (fire)
          armed <= 1'b0; // Held key strobes once
      end
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst)
      cur_key <= 8'h00;
    else if (fire)
      cur_key <= scan_result;
  end

endmodule

`default_nettype wire

// File: keypad_checker.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_checker (
  input logic clk,
  input logic nRst,
  input logic strobe,       // Scanner strobe inside keypad_top
  input logic letter_ready,
  input logic word_valid,
  input logic game_over
);

  // Pulses last one cycle
  a_letter_pulse: assert property (@(posedge clk) disable iff (!nRst)
    letter_ready |=> !letter_ready)
    else $error("letter_ready held for more than one cycle");

  a_word_pulse: assert property (@(posedge clk) disable iff (!nRst)
    word_valid |=> !word_valid)
    else $error("word_valid held for more than one cycle");

  a_strobe_pulse: assert property (@(posedge clk) disable iff (!nRst)
    strobe |=> !strobe)
    else $error("Scanner strobe held for more than one cycle");

  // One event per strobe, so never both at once
  a_not_both: assert property (@(posedge clk) disable iff (!nRst)
    !(letter_ready && word_valid))
    else $error("letter_ready and word_valid in the same cycle");

  a_no_word_after_end: assert property (@(posedge clk) disable iff (!nRst)
    game_over |-> !word_valid)
    else $error("word_valid seen after game_over");

  a_game_over_sticky: assert property (@(posedge clk) disable iff (!nRst)
    game_over |=> game_over)
    else $error("game_over fell without reset");

endmodule

bind keypad_top keypad_checker i_keypad_checker (
  .clk          (clk),
  .nRst         (nRst),
  .strobe       (strobe),
  .letter_ready (letter_ready),
  .word_valid   (word_valid),
  .game_over    (game_over)
);

`default_nettype wire

// File: keypad_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_settings.svh"

module keypad_fsm
  import keypad_pkg::*;
(
  input  logic       clk,
  input  logic       nRst,
  input  logic       strobe,
  input  logic [7:0] cur_key,   // {row, column}
  output kb_event_t  event_out, // One cycle, EV_NONE otherwise
  output logic [7:0] preview    // Letter currently selected
);
  tap_state_e tap;
  tap_state_e next_tap;
  logic [7:0] prev_key;     // Last letter key pressed
  logic [7:0] next_preview;
  logic [7:0] enc_letter;
  kb_event_t  next_event;
  logic       is_letter_key;
  logic       long_set;     // Keys with four letters
  logic       same_key;

  assign is_letter_key = cur_key inside {`KEY_2, `KEY_3, `KEY_4, `KEY_5,
                                         `KEY_6, `KEY_7, `KEY_8, `KEY_9};
  assign long_set = (cur_key == `KEY_7) || (cur_key == `KEY_9);
  assign same_key = (cur_key == prev_key) && (tap != IDLE);

  // Encoder looks at the tap we are moving to, so preview does not lag
  ascii_encoder i_ascii_encoder (
    .row             (cur_key[7:4]),
    .col             (cur_key[3:0]),
    .tap             (next_tap),
    .ascii_character (enc_letter)
  );

  // Tap position
  always_comb begin
    next_tap = tap;
    if (strobe) begin
      case (cur_key)
        `KEY_CLEAR, `KEY_GAME_END, `KEY_SUBMIT_LETTER: next_tap = IDLE;
        default: begin
          if (is_letter_key && same_key) begin
            case (tap)
              TAP0:    next_tap = TAP1;
              TAP1:    next_tap = TAP2;
              TAP2:    next_tap = long_set ? TAP3 : TAP0;
              default: next_tap = TAP0; // TAP3 wraps
            endcase
          end else if (is_letter_key) begin
            next_tap = TAP0; // New key or fresh start
          end
        end
      endcase
    end
  end

  // Preview and event
  always_comb begin
    next_preview = preview;
    next_event   = '{kind: EV_NONE, letter: 8'h00};
    if (strobe) begin
      case (cur_key)
        `KEY_CLEAR: begin
          next_preview    = 8'h00;
          next_event.kind = EV_CLEAR;
        end
        `KEY_GAME_END: begin
          next_preview    = 8'h00;
          next_event.kind = EV_END;
        end
        `KEY_SUBMIT_LETTER: begin
          if (tap != IDLE) // Nothing to commit in IDLE
            next_event = '{kind: EV_LETTER, letter: preview};
        end
        `KEY_SUBMIT_WORD: next_event.kind = EV_WORD;
        default: begin
          if (is_letter_key)
            next_preview = enc_letter;
          // Anything else is an ignored key
        end
      endcase
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      tap       <= IDLE;
      prev_key  <= 8'h00;
      preview   <= 8'h00;
      event_out <= '{kind: EV_NONE, letter: 8'h00};
    end else begin
      tap       <= next_tap;
      preview   <= next_preview;
      event_out <= next_event;
      if (strobe && is_letter_key)
        prev_key <= cur_key; // Ignored keys do not break a tap run
    end
  end

endmodule

`default_nettype wire

// File: keypad_pkg.sv
`default_nettype none

`include "keypad_settings.svh"

package keypad_pkg;

  // Position inside the letter set of the key being tapped
  typedef enum logic [2:0] {
    IDLE, // Nothing selected
    TAP0,
    TAP1,
    TAP2,
    TAP3  // Only reached on keys 7 and 9
  } tap_state_e;

  // What the keypad FSM reports to the word assembler
  typedef enum logic [2:0] {
    EV_NONE,
    EV_LETTER, // Letter committed
    EV_CLEAR,  // Drop partial word
    EV_WORD,   // Word finished
    EV_END     // Game over
  } kb_event_e;

  typedef struct packed {
    kb_event_e  kind;
    logic [7:0] letter; // ASCII, only meaningful with EV_LETTER
  } kb_event_t;

  // First letter sits in letters[0], the lowest byte
  typedef struct packed {
    logic [`WORD_LEN-1:0][7:0] letters;
    logic [2:0]                len;
  } word_t;

endpackage

`default_nettype wire

// File: keypad_settings.svh
`ifndef KEYPAD_SETTINGS_SVH
`define KEYPAD_SETTINGS_SVH

// Scan timing
`define SCAN_DIV       4 // Cycles each column stays driven
`define DEBOUNCE_SCANS 2 // Identical scans before a press counts

`define WORD_LEN 5 // Letters per word

// Key code is {row one-hot, column one-hot}, row 0 and column 0 in the MSB
`define KEY_2             8'b1000_0100 // R0C1
`define KEY_3             8'b1000_0010 // R0C2
`define KEY_4             8'b0100_1000 // R1C0
`define KEY_5             8'b0100_0100 // R1C1
`define KEY_6             8'b0100_0010 // R1C2
`define KEY_7             8'b0010_1000 // R2C0, four letters
`define KEY_8             8'b0010_0100 // R2C1
`define KEY_9             8'b0010_0010 // R2C2, four letters
`define KEY_SUBMIT_LETTER 8'b0001_1000 // R3C0
`define KEY_CLEAR         8'b0001_0100 // R3C1
`define KEY_SUBMIT_WORD   8'b0001_0010 // R3C2
`define KEY_GAME_END      8'b0010_0001 // R2C3

`endif

// File: keypad_top.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_top
  import keypad_pkg::*;
(
  input  logic       clk,
  input  logic       nRst,
  input  logic [3:0] rows,         // Bit 3 is row 0
  output logic [3:0] col_drive,    // One-hot, bit 3 is column 0
  output logic [7:0] preview,
  output logic       letter_ready, // Letter committed this cycle
  output word_t      word,
  output logic       word_valid,
  output logic       game_over
);
  logic       strobe;
  logic [7:0] cur_key;
  kb_event_t  kb_event;

  key_scanner i_key_scanner (
    .clk       (clk),
    .nRst      (nRst),
    .rows      (rows),
    .col_drive (col_drive),
    .strobe    (strobe),
    .cur_key   (cur_key)
  );

  keypad_fsm i_keypad_fsm (
    .clk       (clk),
    .nRst      (nRst),
    .strobe    (strobe),
    .cur_key   (cur_key),
    .event_out (kb_event),
    .preview   (preview)
  );

  assign letter_ready = (kb_event.kind == EV_LETTER);

  word_assembler i_word_assembler (
    .clk        (clk),
    .nRst       (nRst),
    .event_in   (kb_event),
    .word       (word),
    .word_valid (word_valid),
    .game_over  (game_over)
  );

endmodule

`default_nettype wire

// File: tb_keypad.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_settings.svh"

module tb_keypad
  import keypad_pkg::*;
();
  localparam int SCAN_CYCLES    = 4 * `SCAN_DIV;   // One full column scan
  localparam int PRESS_CYCLES   = 5 * SCAN_CYCLES; // 3 scans held, 2 released
  localparam int MAX_PRESSES    = 80;              // Sequence below has 77 at most
  localparam int TIMEOUT_CYCLES = MAX_PRESSES * PRESS_CYCLES + 200;
  localparam logic [7:0] KEY_R0C0 = 8'b1000_1000; // Ignored keys
  localparam logic [7:0] KEY_R0C3 = 8'b1000_0001;
  localparam logic [7:0] KEY_R1C3 = 8'b0100_0001;
  localparam logic [7:0] KEY_R3C3 = 8'b0001_0001;

  logic       clk;
  logic       nRst;
  logic [3:0] rows;
  logic [3:0] col_drive;
  logic [7:0] preview;
  logic       letter_ready;
  word_t      word;
  logic       word_valid;
  logic       game_over;

  logic [7:0] pressed_key;     // Zero when no key is down
  logic [7:0] letter_keys [8];
  logic [7:0] model_key;       // Key of the current tap run
  int         model_taps;      // Presses in the run, 0 is IDLE
  logic [7:0] model_preview;
  logic       model_over;
  logic [7:0] word_q [$];      // Letters of the word being built
  logic [7:0] exp_letters [$]; // Pending letter_ready pulses
  word_t      exp_words [$];   // Pending word_valid pulses
  int         col_idx;         // Column the scanner should be driving
  int         slot_pos;        // Cycles into the current column slot
  integer     seed;
  int         cycles;

  keypad_top i_keypad_top (
    .clk          (clk),
    .nRst         (nRst),
    .rows         (rows),
    .col_drive    (col_drive),
    .preview      (preview),
    .letter_ready (letter_ready),
    .word         (word),
    .word_valid   (word_valid),
    .game_over    (game_over)
  );

  // Keypad matrix: pressed key shorts its row to its column
  assign rows = ((pressed_key[3:0] & col_drive) != 4'b0000) ? pressed_key[7:4] : 4'b0000;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Phone-style multi-tap letter after a number of presses of one key
  function automatic logic [7:0] get_letter(input logic [7:0] key, input int presses);
    string letters;
    case (key)
      `KEY_2:  letters = "ABC";
      `KEY_3:  letters = "DEF";
      `KEY_4:  letters = "GHI";
      `KEY_5:  letters = "JKL";
      `KEY_6:  letters = "MNO";
      `KEY_7:  letters = "PQRS";
      `KEY_8:  letters = "TUV";
      `KEY_9:  letters = "WXYZ";
      default: letters = "";
    endcase
    if (letters.len() == 0 || presses < 1)
      return 8'h00; // Not a letter key
    return letters[(presses - 1) % letters.len()];
  endfunction

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0d ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Value mismatch");
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Run aborted");
  endtask

  task automatic check_letter(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      report_mismatch($sformatf("%s got 0x%h expected 0x%h", what, got, exp));
  endtask

  task automatic check_word(input word_t got, input word_t exp);
    if (got !== exp)
      report_mismatch($sformatf("word got %h len %0d expected %h len %0d",
                                got.letters, got.len, exp.letters, exp.len));
  endtask

  task automatic check_game_over(input logic got, input logic exp);
    if (got !== exp)
      report_mismatch($sformatf("game_over got %b expected %b", got, exp));
  endtask

  task automatic check_col_drive(input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp)
      report_mismatch($sformatf("col_drive got %b expected %b", got, exp));
  endtask

  // Column 0 first, each column held SCAN_DIV cycles
  always @(posedge clk) begin
    if (!nRst) begin
      col_idx  = 0;
      slot_pos = 0;
    end else if (slot_pos == `SCAN_DIV - 1) begin
      col_idx  = (col_idx + 1) % 4;
      slot_pos = 0;
    end else begin
      slot_pos++;
    end
  end

  // Compare process, sampled mid-cycle where outputs are stable
  always @(negedge clk) begin
    if (nRst)
      check_col_drive(col_drive, 4'b1000 >> col_idx);
    if (nRst && letter_ready) begin
      if (exp_letters.size() == 0)
        report_failure("letter_ready pulsed with no letter committed");
      else
        check_letter("letter", preview, exp_letters.pop_front());
    end
    if (nRst && word_valid) begin
      if (exp_words.size() == 0)
        report_failure("word_valid pulsed with no word expected");
      else
        check_word(word, exp_words.pop_front());
    end
  end

  // Update the model, press and release, then check what must have happened
  task automatic do_press(input logic [7:0] key);
    logic [7:0] letter;
    word_t      w;
    if (get_letter(key, 1) != 8'h00) begin
      if (key == model_key && model_taps != 0) begin
        model_taps++; // Same key keeps tapping
      end else begin
        model_key  = key;
        model_taps = 1;
      end
      model_preview = get_letter(key, model_taps);
    end else if (key == `KEY_SUBMIT_LETTER) begin
      if (model_taps != 0) begin // Nothing to commit from IDLE
        letter = get_letter(model_key, model_taps);
        exp_letters.push_back(letter);
        if (!model_over && word_q.size() < `WORD_LEN)
          word_q.push_back(letter); // Extra letters dropped
        model_taps = 0;
      end
    end else if (key == `KEY_CLEAR) begin
      model_taps    = 0;
      model_preview = 8'h00;
      if (!model_over)
        word_q.delete();
    end else if (key == `KEY_SUBMIT_WORD) begin
      if (!model_over) begin
        w = '0;
        foreach (word_q[i])
          w.letters[i] = word_q[i];
        w.len = 3'(word_q.size());
        exp_words.push_back(w);
        word_q.delete();
      end
    end else if (key == `KEY_GAME_END) begin
      model_taps    = 0;
      model_preview = 8'h00;
      model_over    = 1'b1;
    end
    @(posedge clk);
    #1 pressed_key = key;
    repeat (3 * SCAN_CYCLES) @(posedge clk);
    #1 pressed_key = 8'h00;
    repeat (2 * SCAN_CYCLES) @(posedge clk);
    #1;
    if (exp_letters.size() != 0)
      report_failure("letter_ready never arrived for a committed letter");
    if (exp_words.size() != 0)
      report_failure("word_valid never arrived for a submitted word");
    check_letter("preview", preview, model_preview);
    check_game_over(game_over, model_over);
  endtask

  task automatic tap_key(input logic [7:0] key, input int n);
    repeat (n) do_press(key);
  endtask

  // Timeout guard
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $fatal(1, "Timeout");
  end

  initial begin
    int idx;
    int n;
    seed          = 32'h98dc_75c8;
    pressed_key   = 8'h00;
    model_key     = 8'h00;
    model_taps    = 0;
    model_preview = 8'h00;
    model_over    = 1'b0;
    letter_keys   = '{`KEY_2, `KEY_3, `KEY_4, `KEY_5, `KEY_6, `KEY_7, `KEY_8, `KEY_9};
    nRst          = 1'b0;
    repeat (2) @(posedge clk);
    #1 nRst = 1'b1;
    check_letter("preview", preview, 8'h00);
    check_game_over(game_over, 1'b0);

    // Tap cycling and wrap
    tap_key(`KEY_2, 4); // A B C A
    tap_key(`KEY_7, 5); // P Q R S P
    tap_key(`KEY_9, 4);
    do_press(`KEY_3);   // Restart on another key
    do_press(`KEY_CLEAR);

    // Letter commit, commit from IDLE, restart after commit
    tap_key(`KEY_5, 2);
    do_press(`KEY_SUBMIT_LETTER);
    do_press(`KEY_SUBMIT_LETTER); // No pulse
    do_press(`KEY_5);
    do_press(`KEY_SUBMIT_LETTER);
    do_press(`KEY_SUBMIT_WORD);

    // Overflow past WORD_LEN with random keys, then an empty word
    for (int i = 0; i < 6; i++) begin
      idx = $unsigned($random(seed)) % 8;
      n   = $unsigned($random(seed)) % 4 + 1;
      tap_key(letter_keys[idx[2:0]], n);
      do_press(`KEY_SUBMIT_LETTER);
    end
    do_press(`KEY_SUBMIT_WORD);
    do_press(`KEY_SUBMIT_WORD);

    // Clear drops the partial word
    do_press(`KEY_4);
    do_press(`KEY_SUBMIT_LETTER);
    tap_key(`KEY_6, 3);
    do_press(`KEY_SUBMIT_LETTER);
    do_press(`KEY_CLEAR);
    do_press(`KEY_8);
    do_press(`KEY_SUBMIT_LETTER);
    do_press(`KEY_SUBMIT_WORD);

    // Ignored keys leave the tap run alone
    tap_key(`KEY_8, 2);
    do_press(KEY_R0C0);
    do_press(KEY_R0C3);
    do_press(KEY_R1C3);
    do_press(KEY_R3C3);
    do_press(`KEY_8);   // Continues to V
    do_press(`KEY_SUBMIT_LETTER);
    do_press(`KEY_SUBMIT_WORD);

    // Game end, later words go nowhere
    do_press(`KEY_GAME_END);
    do_press(`KEY_2);
    do_press(`KEY_SUBMIT_LETTER); // FSM still commits
    do_press(`KEY_SUBMIT_WORD);
    check_game_over(game_over, 1'b1);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
keypad_pkg.sv
key_scanner.sv
ascii_encoder.sv
keypad_fsm.sv
word_assembler.sv
keypad_top.sv
keypad_checker.sv
tb_keypad.sv

// File: word_assembler.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_settings.svh"

module word_assembler
  import keypad_pkg::*;
(
  input  logic      clk,
  input  logic      nRst,
  input  kb_event_t event_in,
  output word_t     word,       // Held from the last word submit
  output logic      word_valid, // One cycle per submitted word
  output logic      game_over   // Sticky until reset
);
  word_t acc; // Word being built

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      acc        <= '0;
      word       <= '0;
      word_valid <= 1'b0;
      game_over  <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (!game_over) begin // Dead after game end
        case (event_in.kind)
          EV_LETTER: begin
            if (acc.len < 3'(`WORD_LEN)) begin // Full word drops extra letters
              acc.letters[acc.len] <= event_in.letter;
              acc.len              <= acc.len + 3'd1;
            end
          end
          EV_CLEAR: acc <= '0;
          EV_WORD: begin
            word       <= acc; // Empty word goes out with len 0
            word_valid <= 1'b1;
            acc        <= '0;
          end
          EV_END:  game_over <= 1'b1;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire
